// File: common/axi_pkg.sv
// AXI channel types
package axi_pkg;

	localparam int axi_id_width = 4;
	localparam int axi_addr_width = 32;
	localparam int axi_data_width = 64;
	localparam int axi_strb_width = axi_data_width / 8;

	typedef enum logic [1:0] {
		burst_fixed = 2'b00,
		burst_incr = 2'b01,
		burst_wrap = 2'b10
	} axi_burst_e;

	typedef enum logic [1:0] {
		resp_okay = 2'b00,
		resp_slverr = 2'b10
	} axi_resp_e;

	// Shared by AW and AR
	typedef struct packed {
		logic [axi_id_width-1:0] id;
		logic [axi_addr_width-1:0] addr;
		logic [7:0] len;
		logic [2:0] size;
		axi_burst_e burst;
	} axi_ax_t;

	typedef struct packed {
		logic [axi_data_width-1:0] data;
		logic [axi_strb_width-1:0] strb;
		logic last;
	} axi_w_t;

	typedef struct packed {
		logic [axi_id_width-1:0] id;
		axi_resp_e resp;
	} axi_b_t;

	typedef struct packed {
		logic [axi_id_width-1:0] id;
		logic [axi_data_width-1:0] data;
		axi_resp_e resp;
		logic last;
	} axi_r_t;

endpackage

// File: common/ram_pkg.sv
// On-chip RAM geometry and access types
package ram_pkg;

	import axi_pkg::*;

	localparam int ram_bytes = 65536;
	localparam int ram_word_lsb = 3;
	localparam int ram_word_width = 13;
	localparam int ram_words = ram_bytes >> ram_word_lsb;
	localparam int ram_data_width = axi_data_width;
	localparam int ram_be_width = axi_strb_width;

	typedef logic [ram_word_width-1:0] ram_word_t;

	typedef struct packed {
		ram_word_t word;
		logic write;
		logic [ram_be_width-1:0] be;
		logic [ram_data_width-1:0] data;
	} mem_req_t;

	typedef enum logic [1:0] {rd_idle, rd_issue, rd_wait, rd_resp} rd_state_e;
	typedef enum logic [1:0] {wr_idle, wr_data, wr_resp} wr_state_e;

	function automatic ram_word_t start_word(axi_ax_t ax);
		return ax.addr[ram_word_lsb +: ram_word_width];
	endfunction

	// WRAP, reserved burst types and bursts running past the RAM end
	function automatic logic burst_error(axi_ax_t ax);
		logic [axi_addr_width-ram_word_lsb:0] last_word;
		last_word = {1'b0, ax.addr[axi_addr_width-1:ram_word_lsb]};
		if (ax.burst == burst_incr)
			last_word = last_word + ax.len;
		return (ax.burst != burst_incr && ax.burst != burst_fixed) || last_word >= ram_words;
	endfunction

endpackage

// File: rtl/sram_array.sv
// Single-port byte-writable SRAM
`timescale 1ns/1ns
module sram_array import ram_pkg::*; (
	input  logic                      aclk,
	input  mem_req_t                  mem,
	input  logic                      mem_en,
	output logic [ram_data_width-1:0] rdata
);

	logic [ram_data_width-1:0] mem_array [ram_words];

	always_ff @(posedge aclk) begin
		if (mem_en) begin
			if (mem.write) begin
				for (int i = 0; i < ram_be_width; i++) begin
					if (mem.be[i])
						mem_array[mem.word][i*8 +: 8] <= mem.data[i*8 +: 8];
				end
			end else begin
				rdata <= mem_array[mem.word]; // Read data one cycle after the request
			end
		end
	end

endmodule

// File: ram_bridge/axi_write_channel.sv
// AXI write channel engine
`timescale 1ns/1ns
module axi_write_channel import axi_pkg::*, ram_pkg::*; (
	input  logic     aclk,
	input  logic     reset,
	input  axi_ax_t  aw,
	input  logic     aw_valid,
	output logic     aw_ready,
	input  axi_w_t   w,
	input  logic     w_valid,
	output logic     w_ready,
	output axi_b_t   b,
	output logic     b_valid,
	input  logic     b_ready,
	output mem_req_t req,
	output logic     req_valid,
	input  logic     grant
);

	wr_state_e state;
	logic [axi_id_width-1:0] id_q;
	ram_word_t word_q;
	logic incr_q;
	logic err_q;
	logic aw_fire;
	logic w_fire;

	assign aw_fire = aw_valid && aw_ready;
	assign w_fire = w_valid && w_ready;

	// A bad burst still drains its W beats but never reaches the RAM
	assign req_valid = (state == wr_data) && w_valid && !err_q;
	assign w_ready = (state == wr_data) && (err_q || grant);

	assign req.word = word_q;
	assign req.write = 1'b1;
	assign req.be = w.strb; // Strobes map straight onto the byte enables
	assign req.data = w.data;

	assign b.id = id_q;
	assign b.resp = err_q ? resp_slverr : resp_okay;

	always_ff @(posedge aclk) begin
		if (reset) begin
			state <= wr_idle;
			aw_ready <= 1'b0;
			b_valid <= 1'b0;
		end else begin
			case (state)
				wr_idle: begin
					aw_ready <= 1'b1;
					if (aw_fire) begin
						aw_ready <= 1'b0;
						state <= wr_data;
					end
				end
				wr_data: begin
					if (w_fire && w.last)
						state <= wr_resp;
				end
				wr_resp: begin
					b_valid <= 1'b1; // Rises one cycle after entering the state
					if (b_valid && b_ready) begin
						b_valid <= 1'b0;
						aw_ready <= 1'b1;
						state <= wr_idle;
					end
				end
				default: state <= wr_idle;
			endcase
		end
	end

	always_ff @(posedge aclk) begin
		if (aw_fire) begin
			id_q <= aw.id;
			word_q <= start_word(aw);
			incr_q <= (aw.burst == burst_incr);
			err_q <= burst_error(aw);
		end else if (w_fire) begin
			word_q <= word_q + ram_word_t'(incr_q); // FIXED stays on one word
		end
	end

endmodule

// File: ram_bridge/axi_read_channel.sv
// AXI read channel engine
`timescale 1ns/1ns
module axi_read_channel import axi_pkg::*, ram_pkg::*; (
	input  logic                      aclk,
	input  logic                      reset,
	input  axi_ax_t                   ar,
	input  logic                      ar_valid,
	output logic                      ar_ready,
	output axi_r_t                    r,
	output logic                      r_valid,
	input  logic                      r_ready,
	output mem_req_t                  req,
	output logic                      req_valid,
	input  logic                      grant,
	input  logic [ram_data_width-1:0] rdata
);

	rd_state_e state;
	logic [axi_id_width-1:0] id_q;
	logic [7:0] count_q; // Beats still to come after the current one
	ram_word_t word_q;
	logic incr_q;
	logic err_q;
	logic ar_fire;
	logic r_fire;
	logic issue_done;

	assign ar_fire = ar_valid && ar_ready;
	assign r_fire = r_valid && r_ready;

	// Error bursts pass through rd_issue without asking for the port
	assign issue_done = (state == rd_issue) && (err_q || grant);
	assign req_valid = (state == rd_issue) && !err_q;

	assign req.word = word_q;
	assign req.write = 1'b0;
	assign req.be = '0;
	assign req.data = '0;

	assign r_valid = (state == rd_resp);

	always_ff @(posedge aclk) begin
		if (reset) begin
			state <= rd_idle;
			ar_ready <= 1'b0;
			count_q <= 8'd0;
		end else begin
			case (state)
				rd_idle: begin
					ar_ready <= 1'b1;
					if (ar_fire) begin
						ar_ready <= 1'b0;
						count_q <= ar.len;
						state <= rd_issue;
					end
				end
				rd_issue: begin
					if (issue_done)
						state <= rd_wait;
				end
				rd_wait: state <= rd_resp;
				rd_resp: begin
					// Nothing new is issued until the beat is taken
					if (r_fire) begin
						if (count_q == 8'd0) begin
							ar_ready <= 1'b1;
							state <= rd_idle;
						end else begin
							count_q <= count_q - 8'd1;
							state <= rd_issue;
						end
					end
				end
				default: state <= rd_idle;
			endcase
		end
	end

	always_ff @(posedge aclk) begin
		if (ar_fire) begin
			id_q <= ar.id;
			word_q <= start_word(ar);
			incr_q <= (ar.burst == burst_incr);
			err_q <= burst_error(ar);
		end else if (issue_done) begin
			word_q <= word_q + ram_word_t'(incr_q);
		end
	end

	// RAM output is only valid during rd_wait
	always_ff @(posedge aclk) begin
		if (state == rd_wait) begin
			r.id <= id_q;
			r.data <= err_q ? '0 : rdata;
			r.resp <= err_q ? resp_slverr : resp_okay;
			r.last <= (count_q == 8'd0);
		end
	end

endmodule

// File: ram_bridge/ram_port_arbiter.sv
// SRAM port arbiter
`timescale 1ns/1ns
module ram_port_arbiter import ram_pkg::*; (
	input  logic     aclk,
	input  logic     reset,
	input  mem_req_t wr_req,
	input  logic     wr_valid,
	output logic     wr_grant,
	input  mem_req_t rd_req,
	input  logic     rd_valid,
	output logic     rd_grant,
	output mem_req_t mem,
	output logic     mem_en
);

	logic last_rd; // Set when the read side was served most recently

	// On a tie the side that was not served last wins
	assign wr_grant = wr_valid && (!rd_valid || last_rd);
	assign rd_grant = rd_valid && (!wr_valid || !last_rd);

	assign mem = rd_grant ? rd_req : wr_req;
	assign mem_en = wr_grant || rd_grant;

	always_ff @(posedge aclk) begin
		if (reset)
			last_rd <= 1'b0;
		else if (wr_grant)
			last_rd <= 1'b0;
		else if (rd_grant)
			last_rd <= 1'b1;
	end

endmodule

// File: rtl/ram_subsystem.sv
// AXI RAM subsystem top
`timescale 1ns/1ns
module ram_subsystem import axi_pkg::*, ram_pkg::*; (
	input  logic    aclk,
	input  logic    reset,
	input  axi_ax_t aw,
	input  logic    aw_valid,
	output logic    aw_ready,
	input  axi_w_t  w,
	input  logic    w_valid,
	output logic    w_ready,
	output axi_b_t  b,
	output logic    b_valid,
	input  logic    b_ready,
	input  axi_ax_t ar,
	input  logic    ar_valid,
	output logic    ar_ready,
	output axi_r_t  r,
	output logic    r_valid,
	input  logic    r_ready
);

	mem_req_t wr_req;
	logic wr_req_valid;
	logic wr_grant;
	mem_req_t rd_req;
	logic rd_req_valid;
	logic rd_grant;
	mem_req_t mem;
	logic mem_en;
	logic [ram_data_width-1:0] mem_rdata;

	axi_write_channel u_write (
		.aclk     (aclk        ),
		.reset    (reset       ),
		.aw       (aw          ),
		.aw_valid (aw_valid    ),
		.aw_ready (aw_ready    ),
		.w        (w           ),
		.w_valid  (w_valid     ),
		.w_ready  (w_ready     ),
		.b        (b           ),
		.b_valid  (b_valid     ),
		.b_ready  (b_ready     ),
		.req      (wr_req      ),
		.req_valid(wr_req_valid),
		.grant    (wr_grant    )
	);

	axi_read_channel u_read (
		.aclk     (aclk        ),
		.reset    (reset       ),
		.ar       (ar          ),
		.ar_valid (ar_valid    ),
		.ar_ready (ar_ready    ),
		.r        (r           ),
		.r_valid  (r_valid     ),
		.r_ready  (r_ready     ),
		.req      (rd_req      ),
		.req_valid(rd_req_valid),
		.grant    (rd_grant    ),
		.rdata    (mem_rdata   )
	);

	ram_port_arbiter u_arbiter (
		.aclk    (aclk        ),
		.reset   (reset       ),
		.wr_req  (wr_req      ),
		.wr_valid(wr_req_valid),
		.wr_grant(wr_grant    ),
		.rd_req  (rd_req      ),
		.rd_valid(rd_req_valid),
		.rd_grant(rd_grant    ),
		.mem     (mem         ),
		.mem_en  (mem_en      )
	);

	sram_array u_sram (
		.aclk  (aclk     ),
		.mem   (mem      ),
		.mem_en(mem_en   ),
		.rdata (mem_rdata)
	);

endmodule

// File: bench/tb_ram_subsystem.sv
// RAM subsystem testbench
`timescale 1ns/1ns
module tb_ram_subsystem import axi_pkg::*, ram_pkg::*; ();

	localparam int cycle_limit = 20000; // All tests together take a few thousand cycles

	logic aclk;
	logic reset;
	axi_ax_t aw;
	logic aw_valid;
	logic aw_ready;
	axi_w_t w;
	logic w_valid;
	logic w_ready;
	axi_b_t b;
	logic b_valid;
	logic b_ready;
	axi_ax_t ar;
	logic ar_valid;
	logic ar_ready;
	axi_r_t r;
	logic r_valid;
	logic r_ready;

	logic [63:0] shadow [ram_words]; // Mirrors every accepted in-range write beat
	logic [31:0] rng_state = 32'd39;
	int cycles = 0;
	int errors = 0;
	int checks = 0;

	ram_subsystem UUT (.*);

	initial aclk = 1'b0;
	always #2 aclk = ~aclk;

	always @(posedge aclk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("Timeout after %0d cycles, the run was stopped", cycles);
			$display("TB FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift();
		logic [31:0] x;
		x = rng_state;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng_state = x;
		return x;
	endfunction

	task automatic report_fail(input string msg);
		errors++;
		$display("Fail at %0t ns: %s", $time, msg);
	endtask

	// Payloads hold while the master stalls
	assert property (@(posedge aclk) disable iff (reset)
		r_valid && !r_ready |=> r_valid && $stable(r))
		else report_fail("R payload changed while rready was low");
	assert property (@(posedge aclk) disable iff (reset)
		b_valid && !b_ready |=> b_valid && $stable(b))
		else report_fail("B payload changed while bready was low");

	// A losing channel wins the very next cycle
	assert property (@(posedge aclk) disable iff (reset)
		UUT.rd_req_valid && !UUT.rd_grant |=> UUT.rd_grant)
		else report_fail("read channel kept waiting for the RAM port");
	assert property (@(posedge aclk) disable iff (reset)
		UUT.wr_req_valid && !UUT.wr_grant |=> UUT.wr_grant)
		else report_fail("write channel kept waiting for the RAM port");

	assert property (@(posedge aclk) $fell(reset) |->
		!aw_ready && !ar_ready && !b_valid && !r_valid ##1 aw_ready && ar_ready)
		else report_fail("ready and valid levels wrong after reset");

	task automatic write_burst(input logic [3:0] id, input logic [31:0] addr,
			input logic [7:0] len, input axi_burst_e burst, input logic exp_err,
			input logic full_strb, input logic rand_ready);
		int word;
		logic done;
		logic [31:0] rnd;
		axi_resp_e exp_resp;
		exp_resp = exp_err ? resp_slverr : resp_okay;
		@(negedge aclk);
		aw = '{id: id, addr: addr, len: len, size: 3'd3, burst: burst};
		aw_valid = 1'b1;
		do begin
			#1 done = aw_ready;
			@(negedge aclk);
		end while (!done);
		aw_valid = 1'b0;
		word = addr[15:3];
		for (int i = 0; i <= len; i++) begin
			rnd = xorshift();
			w.data = {xorshift(), xorshift()};
			w.strb = full_strb ? 8'hff : rnd[7:0];
			w.last = (i == len);
			w_valid = 1'b1;
			do begin
				#1 done = w_ready;
				@(negedge aclk);
			end while (!done);
			if (!exp_err) begin
				for (int k = 0; k < 8; k++) begin
					if (w.strb[k])
						shadow[word][k*8 +: 8] = w.data[k*8 +: 8];
				end
			end
			if (burst == burst_incr)
				word++;
		end
		w_valid = 1'b0;
		do begin
			rnd = xorshift();
			b_ready = !rand_ready || rnd[0];
			#1 done = b_valid && b_ready;
			if (done) begin
				checks++;
				assert (b.id == id && b.resp == exp_resp)
					else report_fail($sformatf("B for %h: id %h resp %0d", addr, b.id, b.resp));
			end
			@(negedge aclk);
		end while (!done);
		b_ready = 1'b0;
	endtask

	task automatic read_burst(input logic [3:0] id, input logic [31:0] addr,
			input logic [7:0] len, input axi_burst_e burst, input logic exp_err,
			input logic rand_ready);
		int word;
		int beat;
		logic done;
		logic [31:0] rnd;
		logic [63:0] expected;
		axi_resp_e exp_resp;
		exp_resp = exp_err ? resp_slverr : resp_okay;
		@(negedge aclk);
		ar = '{id: id, addr: addr, len: len, size: 3'd3, burst: burst};
		ar_valid = 1'b1;
		do begin
			#1 done = ar_ready;
			@(negedge aclk);
		end while (!done);
		ar_valid = 1'b0;
		word = addr[15:3];
		beat = 0;
		while (beat <= len) begin
			rnd = xorshift();
			r_ready = !rand_ready || rnd[0];
			#1;
			if (r_valid && r_ready) begin
				expected = exp_err ? 64'd0 : shadow[word];
				checks++;
				assert (r.id == id && r.resp == exp_resp && r.last == (beat == len)
						&& r.data === expected)
					else report_fail($sformatf("R beat %0d of %h: data %h last %b, expected %h",
						beat, addr, r.data, r.last, expected));
				beat++;
				if (burst == burst_incr)
					word++;
			end
			@(negedge aclk);
		end
		r_ready = 1'b0;
	endtask

	initial begin
		logic [31:0] rnd;
		logic [31:0] addr;
		logic [7:0] len;
		reset = 1'b1;
		aw = '0;
		aw_valid = 1'b0;
		w = '0;
		w_valid = 1'b0;
		b_ready = 1'b0;
		ar = '0;
		ar_valid = 1'b0;
		r_ready = 1'b0;
		repeat (16) @(negedge aclk);
		reset = 1'b0;

		// INCR burst with random strobes over a preloaded range
		write_burst(4'h3, 32'h0000_0100, 8'd15, burst_incr, 1'b0, 1'b1, 1'b0);
		write_burst(4'h5, 32'h0000_0100, 8'd15, burst_incr, 1'b0, 1'b0, 1'b0);
		read_burst(4'h9, 32'h0000_0100, 8'd15, burst_incr, 1'b0, 1'b0);

		// Later beats of a FIXED burst override earlier bytes
		write_burst(4'h1, 32'h0000_2000, 8'd0, burst_incr, 1'b0, 1'b1, 1'b0);
		write_burst(4'h2, 32'h0000_2000, 8'd3, burst_fixed, 1'b0, 1'b0, 1'b0);
		read_burst(4'h2, 32'h0000_2000, 8'd0, burst_incr, 1'b0, 1'b0);
		read_burst(4'h4, 32'h0000_2000, 8'd2, burst_fixed, 1'b0, 1'b0);

		// Bursts running past the end of the RAM
		write_burst(4'h6, 32'h0000_fff0, 8'd1, burst_incr, 1'b0, 1'b1, 1'b0);
		write_burst(4'h7, 32'h0000_fff0, 8'd3, burst_incr, 1'b1, 1'b1, 1'b0);
		read_burst(4'h7, 32'h0000_fff0, 8'd3, burst_incr, 1'b1, 1'b0);
		read_burst(4'h8, 32'h0000_fff0, 8'd1, burst_incr, 1'b0, 1'b0);

		write_burst(4'ha, 32'h0000_0100, 8'd3, burst_wrap, 1'b1, 1'b1, 1'b0);
		read_burst(4'hb, 32'h0000_0100, 8'd3, burst_wrap, 1'b1, 1'b0);
		read_burst(4'hc, 32'h0000_0100, 8'd15, burst_incr, 1'b0, 1'b0);

		// Random back pressure on B and R
		for (int i = 0; i < 12; i++) begin
			rnd = xorshift();
			addr = {16'd0, 3'b001, rnd[9:0], 3'd0};
			len = {4'd0, rnd[13:10]};
			write_burst(rnd[17:14], addr, len, burst_incr, 1'b0, 1'b1, 1'b1);
			read_burst(rnd[21:18], addr, len, burst_incr, 1'b0, 1'b1);
		end

		fork
			write_burst(4'hd, 32'h0000_8000, 8'd31, burst_incr, 1'b0, 1'b1, 1'b0);
			read_burst(4'he, 32'h0000_0100, 8'd15, burst_incr, 1'b0, 1'b0);
		join
		read_burst(4'hf, 32'h0000_8000, 8'd31, burst_incr, 1'b0, 1'b0);

		repeat (4) @(negedge aclk);
		$display("Checked %0d responses, %0d errors", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// File: ram_subsystem.f
common/axi_pkg.sv
common/ram_pkg.sv
rtl/sram_array.sv
ram_bridge/axi_write_channel.sv
ram_bridge/axi_read_channel.sv
ram_bridge/ram_port_arbiter.sv
rtl/ram_subsystem.sv
bench/tb_ram_subsystem.sv

// File: Bender.yml
package:
  name: ram_subsystem

sources:
  - common/axi_pkg.sv
  - common/ram_pkg.sv
  - rtl/sram_array.sv
  - ram_bridge/axi_write_channel.sv
  - ram_bridge/axi_read_channel.sv
  - ram_bridge/ram_port_arbiter.sv
  - rtl/ram_subsystem.sv
  - target: test
    files:
      - bench/tb_ram_subsystem.sv
